/* Makefile */
# Verilator build and run for the JESD204 LMFC timing testbench

VERILATOR       ?= verilator
TOP             ?= tb_jesd_timing
RTL_TOP         ?= jesd_timing_top
FILELIST        ?= all.f
DATA_PATH_WIDTH ?= 4
SEED            ?= 6
BUILD_DIR       ?= obj_dir_w$(DATA_PATH_WIDTH)
LOG             ?= sim_w$(DATA_PATH_WIDTH).log
VFLAGS          ?= --binary --timing --assert
LINT_FLAGS      ?= --lint-only --timing
PASS_TEXT       ?= Done: no errors

.PHONY: all build run run8 lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GDATA_PATH_WIDTH=$(DATA_PATH_WIDTH) -GSEED=$(SEED) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

# Second run with the 8-byte data path
run8:
	$(MAKE) run DATA_PATH_WIDTH=8

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir_w* sim_w*.log

/* all.f */
rtl/jesd_timing_pkg.sv
rtl/timing_cfg_if.sv
rtl/cfg_regs.sv
rtl/sysref_capture.sv
rtl/lmfc_counter.sv
rtl/jesd_timing_top.sv
verification/tb_jesd_timing.sv

/* rtl/cfg_regs.sv */
// Host must write only while reset is high, and the first reset clock restores defaults
`timescale 1ns/10ps

module cfg_regs import jesd_timing_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cfg_req,
  output logic                   cfg_ack,
  input  cfg_addr_t              cfg_addr,
  input  logic [CFG_WDATA_W-1:0] cfg_wdata,
  timing_cfg_if.src              cfg
);

  // Delayed reset, marks the first clock of a reset period
  logic reset_d = 1'b0;
  logic reset_start;
  // Accept on a fresh request only
  logic write_en;

  assign reset_start = reset & ~reset_d;
  assign write_en = cfg_req & ~cfg_ack;

  always_ff @(posedge clk) begin
    reset_d <= reset;
  end

  // ******************************
  // Four-phase acknowledge
  // ******************************

  always_ff @(posedge clk) begin
    if (reset_start) begin
      cfg_ack <= 1'b0;
    end else if (write_en) begin
      // Raise ack with the write
      cfg_ack <= 1'b1;
    end else if (cfg_ack && !cfg_req) begin
      // Host released, close the cycle
      cfg_ack <= 1'b0;
    end
  end

  // ******************************
  // Configuration registers
  // ******************************

  always_ff @(posedge clk) begin
    if (reset_start) begin
      cfg.octets_per_mf  <= DEF_OCTETS_PER_MF;
      cfg.beats_per_mf   <= DEF_BEATS_PER_MF;
      cfg.lmfc_offset    <= DEF_LMFC_OFFSET;
      cfg.sysref_oneshot <= 1'b0;
      cfg.sysref_disable <= 1'b0;
    end else if (write_en) begin
      case (cfg_addr)
        REG_OCTETS_PER_MF: cfg.octets_per_mf <= cfg_wdata[OCTETS_W-1:0];
        REG_BEATS_PER_MF:  cfg.beats_per_mf <= cfg_wdata[BEAT_W-1:0];
        REG_LMFC_OFFSET:   cfg.lmfc_offset <= cfg_wdata[BEAT_W-1:0];
        REG_CTRL: begin
          cfg.sysref_oneshot <= cfg_wdata[CTRL_ONESHOT_BIT];
          cfg.sysref_disable <= cfg_wdata[CTRL_DISABLE_BIT];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* rtl/jesd_timing_pkg.sv */
// Shared link timing constants; beats_per_mf doubled must still fit in BEAT_W bits
package jesd_timing_pkg;

  // ******************************
  // Register map
  // ******************************

  typedef logic [1:0] cfg_addr_t;

  localparam cfg_addr_t REG_OCTETS_PER_MF = 2'd0;
  localparam cfg_addr_t REG_BEATS_PER_MF  = 2'd1;
  localparam cfg_addr_t REG_LMFC_OFFSET   = 2'd2;
  localparam cfg_addr_t REG_CTRL          = 2'd3;

  // Host write data bus
  localparam int CFG_WDATA_W = 16;

  // Field widths
  localparam int OCTETS_W = 10;
  localparam int BEAT_W   = 8;

  // Link mode codes for the LINK_MODE parameter
  localparam int LINK_8B10B  = 1;
  localparam int LINK_64B66B = 2;

  // Control register bits
  localparam int CTRL_ONESHOT_BIT = 0;
  localparam int CTRL_DISABLE_BIT = 1;

  // ******************************
  // Reset defaults
  // ******************************

  // Octets per multiframe minus one, F=1 K=32
  localparam logic [OCTETS_W-1:0] DEF_OCTETS_PER_MF = 10'd31;
  // Beats per multiframe minus one at 4 bytes per beat
  localparam logic [BEAT_W-1:0] DEF_BEATS_PER_MF = 8'd7;
  localparam logic [BEAT_W-1:0] DEF_LMFC_OFFSET = 8'd0;

endpackage

/* rtl/jesd_timing_top.sv */
// Single link clock domain, SYSREF is the only asynchronous input
`timescale 1ns/10ps

module jesd_timing_top import jesd_timing_pkg::*; #(
  parameter int DATA_PATH_WIDTH = 4,
  parameter int LINK_MODE       = LINK_8B10B,
  parameter int SYNC_STAGES     = 2
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   sysref,
  // Host register port
  input  logic                   cfg_req,
  output logic                   cfg_ack,
  input  cfg_addr_t              cfg_addr,
  input  logic [CFG_WDATA_W-1:0] cfg_wdata,
  output logic                   sysref_edge,
  // LMFC timing outputs
  output logic                   lmfc_edge,
  output logic                   lmfc_clk,
  output logic [BEAT_W-1:0]      lmfc_count,
  output logic                   lmc_edge,
  output logic                   lmc_quarter_edge,
  output logic                   eoemb,
  output logic                   sysref_alignment_error
);

  // Active configuration shared by all blocks
  timing_cfg_if u_cfg_if ();

  cfg_regs u_cfg_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_req   (cfg_req),
    .cfg_ack   (cfg_ack),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (u_cfg_if.src)
  );

  sysref_capture #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_sysref_capture (
    .clk         (clk),
    .sysref      (sysref),
    .cfg         (u_cfg_if.capture),
    .sysref_edge (sysref_edge)
  );

  lmfc_counter #(
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH),
    .LINK_MODE       (LINK_MODE)
  ) u_lmfc_counter (
    .clk                    (clk),
    .reset                  (reset),
    .sysref_edge            (sysref_edge),
    .cfg                    (u_cfg_if.lmfc_counter),
    .lmfc_edge              (lmfc_edge),
    .lmfc_clk               (lmfc_clk),
    .lmfc_count             (lmfc_count),
    .lmc_edge               (lmc_edge),
    .lmc_quarter_edge       (lmc_quarter_edge),
    .eoemb                  (eoemb),
    .sysref_alignment_error (sysref_alignment_error)
  );

endmodule

/* rtl/lmfc_counter.sv */
// Configuration must be static out of reset, and whole_beats must fit in BEAT_W bits
`timescale 1ns/10ps

module lmfc_counter import jesd_timing_pkg::*; #(
  parameter int DATA_PATH_WIDTH = 4,
  parameter int LINK_MODE       = LINK_8B10B
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               sysref_edge,
  timing_cfg_if.lmfc_counter cfg,
  output logic               lmfc_edge,
  output logic               lmfc_clk,
  output logic [BEAT_W-1:0]  lmfc_count,
  output logic               lmc_edge,
  output logic               lmc_quarter_edge,
  output logic               eoemb,
  output logic               sysref_alignment_error
);

  // 8B/10B on an 8-byte path may leave a half beat per multiframe
  localparam bit CAN_DOUBLE = (LINK_MODE == LINK_8B10B) && (DATA_PATH_WIDTH == 8);

  // Last counter value of one multiframe
  logic [BEAT_W-1:0] whole_beats;
  logic [BEAT_W-1:0] count_next;
  // Seen at least one SYSREF edge since reset
  logic captured;
  // Counter carries a valid phase
  logic active;
  // Reload allowed on this edge
  logic reload;
  // LMFC clock before its output register
  logic lmfc_clk_p1;

  // ******************************
  // Multiframe length
  // ******************************

  // Half beat left when octet count bit 2 is clear, so run two multiframes
  always_comb begin
    if (CAN_DOUBLE && !cfg.octets_per_mf[2]) begin
      whole_beats = {cfg.beats_per_mf[BEAT_W-2:0], 1'b0};
    end else begin
      whole_beats = cfg.beats_per_mf;
    end
  end

  // Wrap at the end of the multiframe
  assign count_next = (lmfc_count == whole_beats) ? '0 : lmfc_count + 1'b1;

  // Oneshot keeps only the first SYSREF
  assign reload = sysref_edge & (~cfg.sysref_oneshot | ~captured);

  // ******************************
  // Beat counter
  // ******************************

  always_ff @(posedge clk) begin
    if (reset) begin
      captured <= 1'b0;
    end else if (sysref_edge) begin
      captured <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // Free-running start point when SYSREF is off
      lmfc_count <= 'd1;
      active <= cfg.sysref_disable;
    end else if (reload) begin
      lmfc_count <= cfg.lmfc_offset;
      active <= 1'b1;
    end else begin
      lmfc_count <= count_next;
    end
  end

  // ******************************
  // Alignment check
  // ******************************

  // SYSREF phase against the running count, also in oneshot mode
  always_ff @(posedge clk) begin
    if (reset) begin
      sysref_alignment_error <= 1'b0;
    end else begin
      sysref_alignment_error <= sysref_edge & active & (count_next != cfg.lmfc_offset);
    end
  end

  // ******************************
  // Markers
  // ******************************

  always_ff @(posedge clk) begin
    if (reset) begin
      lmfc_edge <= 1'b0;
      lmc_edge <= 1'b0;
      lmc_quarter_edge <= 1'b0;
      eoemb <= 1'b0;
    end else begin
      lmfc_edge <= active & (lmfc_count == '0);
      // Multiblock is 32 blocks
      lmc_edge <= active & (lmfc_count[4:0] == 5'd0);
      // Quarter multiblock, 8 blocks
      lmc_quarter_edge <= active & (lmfc_count[2:0] == 3'd0);
      // Last multiblock of the extended multiblock
      eoemb <= active & (lmfc_count[7:5] == whole_beats[7:5]);
    end
  end

  // ******************************
  // LMFC clock
  // ******************************

  // High from the multiframe end to its midpoint
  always_ff @(posedge clk) begin
    if (reset) begin
      lmfc_clk_p1 <= 1'b0;
    end else if (active) begin
      if (lmfc_count == whole_beats) begin
        lmfc_clk_p1 <= 1'b1;
      end else if (lmfc_count == {1'b0, whole_beats[BEAT_W-1:1]}) begin
        lmfc_clk_p1 <= 1'b0;
      end
    end
  end

  // Extra stage on the clock output
  always_ff @(posedge clk) begin
    if (reset) begin
      lmfc_clk <= 1'b0;
    end else begin
      lmfc_clk <= lmfc_clk_p1;
    end
  end

endmodule

/* rtl/sysref_capture.sv */
// SYNC_STAGES must be 2 or more, and the edge appears SYNC_STAGES+3 clocks after sampling
`timescale 1ns/10ps

module sysref_capture #(
  parameter int SYNC_STAGES = 2
) (
  input  logic          clk,
  input  logic          sysref,
  timing_cfg_if.capture cfg,
  output logic          sysref_edge
);

  // ******************************
  // Input synchronizer
  // ******************************

  // Asynchronous SYSREF enters here
  logic [SYNC_STAGES-1:0] sync_q = '0;

  always_ff @(posedge clk) begin
    sync_q <= {sync_q[SYNC_STAGES-2:0], sysref};
  end

  // ******************************
  // Extra delay stages
  // ******************************

  // SYSREF setup and hold to the device clock is often not met.
  // These stages keep a late settling value away from the counter.
  logic [2:0] dly_q = '0;

  always_ff @(posedge clk) begin
    dly_q <= {dly_q[1:0], sync_q[SYNC_STAGES-1]};
  end

  // ******************************
  // Rising edge detect
  // ******************************

  // Low-to-high between the last two stages
  logic rise;

  assign rise = dly_q[1] & ~dly_q[2];

  // One-cycle pulse blocked while SYSREF is disabled
  always_ff @(posedge clk) begin
    sysref_edge <= rise & ~cfg.sysref_disable;
  end

endmodule

/* rtl/timing_cfg_if.sv */
// Configuration is static outside reset and no handshake travels with these signals
`timescale 1ns/10ps

interface timing_cfg_if import jesd_timing_pkg::*; ();

  // Multiframe length and alignment offset
  logic [OCTETS_W-1:0] octets_per_mf;
  logic [BEAT_W-1:0] beats_per_mf;
  logic [BEAT_W-1:0] lmfc_offset;

  // SYSREF handling controls
  logic sysref_oneshot;
  logic sysref_disable;

  // Register block drives everything
  modport src (
    output octets_per_mf,
    output beats_per_mf,
    output lmfc_offset,
    output sysref_oneshot,
    output sysref_disable
  );

  // Counter needs the whole set
  modport lmfc_counter (
    input octets_per_mf,
    input beats_per_mf,
    input lmfc_offset,
    input sysref_oneshot,
    input sysref_disable
  );

  // Capture only gates its edge
  modport capture (
    input sysref_disable
  );

endinterface

/* verification/tb_jesd_timing.sv */
// Config writes happen only in reset; one run covers one DATA_PATH_WIDTH, SEED sets the SYSREF gaps
`timescale 1ns/10ps

module tb_jesd_timing import jesd_timing_pkg::*; #(
  parameter int DATA_PATH_WIDTH = 4,
  parameter int SEED            = 6
);

  localparam int LINK_MODE    = LINK_8B10B;
  localparam int SYNC_STAGES  = 2;
  localparam int RESET_CYCLES = 5;
  // Longest stimulus is near 2000 cycles at the doubled multiframe
  localparam int MAX_CYCLES   = 4000;

  // DUT inputs, all start at known values
  logic clk = 1'b0;
  logic reset = 1'b1;
  logic sysref = 1'b0;
  logic cfg_req = 1'b0;
  cfg_addr_t cfg_addr = REG_OCTETS_PER_MF;
  logic [CFG_WDATA_W-1:0] cfg_wdata = '0;
  // DUT outputs
  logic cfg_ack, sysref_edge, sysref_alignment_error;
  logic lmfc_edge, lmfc_clk, lmc_edge, lmc_quarter_edge, eoemb;
  logic [BEAT_W-1:0] lmfc_count;

  // Configuration as last written by the host task
  logic [OCTETS_W-1:0] set_octets = '0;
  logic [BEAT_W-1:0] set_beats = '0;
  logic [BEAT_W-1:0] set_offset = '0;
  logic set_oneshot = 1'b0;
  logic set_disable = 1'b0;

  // Reference model state
  logic [SYNC_STAGES+3:0] sr_hist = '0;
  logic reset_q = 1'b0;
  logic exp_ack = 1'b0;
  logic exp_edge, exp_active, exp_captured, exp_clk_hold;
  logic exp_lmfc_edge, exp_lmc_edge, exp_quarter, exp_eoemb, exp_lmfc_clk, exp_align_err;
  logic [BEAT_W-1:0] exp_count, exp_next, whole_beats;

  int cycles = 0;
  int err_cnt [5] = '{default: 0};

  always #50 clk = ~clk;

  jesd_timing_top #(
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH),
    .LINK_MODE       (LINK_MODE),
    .SYNC_STAGES     (SYNC_STAGES)
  ) u_jesd_timing_top (
    .clk                    (clk),
    .reset                  (reset),
    .sysref                 (sysref),
    .cfg_req                (cfg_req),
    .cfg_ack                (cfg_ack),
    .cfg_addr               (cfg_addr),
    .cfg_wdata              (cfg_wdata),
    .sysref_edge            (sysref_edge),
    .lmfc_edge              (lmfc_edge),
    .lmfc_clk               (lmfc_clk),
    .lmfc_count             (lmfc_count),
    .lmc_edge               (lmc_edge),
    .lmc_quarter_edge       (lmc_quarter_edge),
    .eoemb                  (eoemb),
    .sysref_alignment_error (sysref_alignment_error)
  );

  // ******************************
  // Reference model
  // ******************************

  // Doubled multiframe when 8B/10B on 8 bytes leaves a half beat
  assign whole_beats = (DATA_PATH_WIDTH == 8 && LINK_MODE == LINK_8B10B && !set_octets[2]) ?
                       (set_beats << 1) : set_beats;
  assign exp_next = (exp_count == whole_beats) ? 8'd0 : exp_count + 8'd1;
  // SYSREF rise seen SYNC_STAGES+3 clocks after sampling
  assign exp_edge = sr_hist[SYNC_STAGES+2] & ~sr_hist[SYNC_STAGES+3] & ~set_disable;

  always @(posedge clk) begin
    sr_hist <= {sr_hist[SYNC_STAGES+2:0], sysref};
    reset_q <= reset;
    // Ack follows req one clock later, cleared on the first reset clock
    exp_ack <= (reset && !reset_q) ? 1'b0 : cfg_req;
  end

  always @(posedge clk) begin
    if (reset) begin
      exp_count <= 8'd1;
      exp_active <= set_disable;
      exp_captured <= 1'b0;
      exp_clk_hold <= 1'b0;
    end else begin
      if (exp_edge) begin
        exp_captured <= 1'b1;
      end
      // Oneshot ignores every edge after the first
      if (exp_edge && !(set_oneshot && exp_captured)) begin
        exp_count <= set_offset;
        exp_active <= 1'b1;
      end else begin
        exp_count <= exp_next;
      end
      if (exp_active && exp_count == whole_beats) begin
        exp_clk_hold <= 1'b1;
      end else if (exp_active && exp_count == (whole_beats >> 1)) begin
        exp_clk_hold <= 1'b0;
      end
    end
  end

  // Markers one clock behind the count they decode
  always @(posedge clk) begin
    if (reset) begin
      exp_lmfc_edge <= 1'b0;
      exp_lmc_edge <= 1'b0;
      exp_quarter <= 1'b0;
      exp_eoemb <= 1'b0;
      exp_lmfc_clk <= 1'b0;
      exp_align_err <= 1'b0;
    end else begin
      exp_lmfc_edge <= exp_active && (exp_count == 8'd0);
      exp_lmc_edge <= exp_active && (exp_count[4:0] == 5'd0);
      exp_quarter <= exp_active && (exp_count[2:0] == 3'd0);
      exp_eoemb <= exp_active && (exp_count[7:5] == whole_beats[7:5]);
      exp_lmfc_clk <= exp_clk_hold;
      exp_align_err <= exp_edge && exp_active && (exp_next != set_offset);
    end
  end

  // ******************************
  // Checks
  // ******************************

  // Groups 0 handshake, 1 sysref, 2 count, 3 markers, 4 alignment
  task automatic flag_value(input int grp, input string name, input logic [31:0] got,
                            input logic [31:0] want);
    err_cnt[grp] = err_cnt[grp] + 1;
    $display("ERR %s got 0x%0h expected 0x%0h at cycle %0d", name, got, want, cycles);
  endtask

  assert property (@(posedge clk) disable iff (cycles == 0) cfg_ack == exp_ack)
    else flag_value(0, "cfg_ack", 32'($sampled(cfg_ack)), 32'($sampled(exp_ack)));
  assert property (@(posedge clk) disable iff (reset) sysref_edge == exp_edge)
    else flag_value(1, "sysref_edge", 32'($sampled(sysref_edge)), 32'($sampled(exp_edge)));
  assert property (@(posedge clk) disable iff (reset) lmfc_count == exp_count)
    else flag_value(2, "lmfc_count", 32'($sampled(lmfc_count)), 32'($sampled(exp_count)));
  assert property (@(posedge clk) disable iff (reset) lmfc_edge == exp_lmfc_edge)
    else flag_value(3, "lmfc_edge", 32'($sampled(lmfc_edge)), 32'($sampled(exp_lmfc_edge)));
  assert property (@(posedge clk) disable iff (reset) lmc_edge == exp_lmc_edge)
    else flag_value(3, "lmc_edge", 32'($sampled(lmc_edge)), 32'($sampled(exp_lmc_edge)));
  assert property (@(posedge clk) disable iff (reset) lmc_quarter_edge == exp_quarter)
    else flag_value(3, "lmc_quarter_edge", 32'($sampled(lmc_quarter_edge)),
                    32'($sampled(exp_quarter)));
  assert property (@(posedge clk) disable iff (reset) eoemb == exp_eoemb)
    else flag_value(3, "eoemb", 32'($sampled(eoemb)), 32'($sampled(exp_eoemb)));
  assert property (@(posedge clk) disable iff (reset) lmfc_clk == exp_lmfc_clk)
    else flag_value(3, "lmfc_clk", 32'($sampled(lmfc_clk)), 32'($sampled(exp_lmfc_clk)));
  assert property (@(posedge clk) disable iff (reset) sysref_alignment_error == exp_align_err)
    else flag_value(4, "sysref_alignment_error", 32'($sampled(sysref_alignment_error)),
                    32'($sampled(exp_align_err)));

  // ******************************
  // Stimulus tasks
  // ******************************

  // Entered and left 10 ns after a rising edge
  task automatic host_write(input cfg_addr_t addr, input logic [CFG_WDATA_W-1:0] data);
    cfg_addr = addr;
    cfg_wdata = data;
    cfg_req = 1'b1;
    do begin
      @(posedge clk);
      #10;
    end while (!cfg_ack);
    cfg_req = 1'b0;
    do begin
      @(posedge clk);
      #10;
    end while (cfg_ack);
  endtask

  // Reset, host writes inside reset, then release
  task automatic configure_link(input logic [OCTETS_W-1:0] octets, input logic [BEAT_W-1:0] beats,
                                input logic [BEAT_W-1:0] offset, input logic [1:0] ctrl);
    reset = 1'b1;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #10;
    end
    host_write(REG_OCTETS_PER_MF, {6'd0, octets});
    host_write(REG_BEATS_PER_MF, {8'd0, beats});
    host_write(REG_LMFC_OFFSET, {8'd0, offset});
    host_write(REG_CTRL, {14'd0, ctrl});
    set_octets = octets;
    set_beats = beats;
    set_offset = offset;
    set_oneshot = ctrl[CTRL_ONESHOT_BIT];
    set_disable = ctrl[CTRL_DISABLE_BIT];
    @(posedge clk);
    #10;
    reset = 1'b0;
    repeat (20) begin
      @(posedge clk);
      #10;
    end
  endtask

  // Pulse high for 4 clocks, next pulse starts spacing clocks later
  task automatic send_sysref(input int spacing);
    sysref = 1'b1;
    repeat (4) @(posedge clk);
    #10;
    sysref = 1'b0;
    repeat (spacing - 4) @(posedge clk);
    #10;
  endtask

  function automatic int total_errors();
    int sum;
    sum = 0;
    foreach (err_cnt[i]) begin
      sum = sum + err_cnt[i];
    end
    return sum;
  endfunction

  task automatic print_summary();
    $display("Error counts: handshake %0d, sysref %0d, count %0d, markers %0d, alignment %0d",
             err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3], err_cnt[4]);
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    int period;
    void'($urandom(SEED));
    // Every SYSREF edge reloads the counter
    configure_link(10'd283, 8'd35, 8'd5, 2'b00);
    period = int'(whole_beats) + 1;
    repeat (4) send_sysref(period * (1 + int'($urandom % 3)));
    // Next pulse lands 3 beats late and realigns
    send_sysref(2 * period + 3);
    send_sysref(period);
    send_sysref(period * (1 + int'($urandom % 3)));
    // Oneshot keeps the first phase but still flags late pulses
    configure_link(10'd283, 8'd35, 8'd5, 2'b01);
    repeat (2) send_sysref(period * (1 + int'($urandom % 3)));
    send_sysref(period + 3);
    send_sysref(period);
    send_sysref(period);
    // Disabled SYSREF, counter free-runs from reset
    configure_link(10'd283, 8'd35, 8'd5, 2'b10);
    repeat (2) send_sysref(period);
    repeat (2 * period) @(posedge clk);
    #10;
    print_summary();
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Cycle limit guards against a stuck handshake
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles before the stimulus finished", MAX_CYCLES);
      print_summary();
      $display("Done: errors found");
      $finish;
    end
  end

endmodule
